// File: logic/dino_consts.svh
/* Runner game constants */
`ifndef DINO_CONSTS_SVH
`define DINO_CONSTS_SVH

// Raster timing in pixels and lines
`define DINO_H_ACTIVE 1280
`define DINO_H_FRONT 32
`define DINO_H_SYNC 192
`define DINO_H_BACK 96
`define DINO_V_ACTIVE 480
`define DINO_V_FRONT 10
`define DINO_V_SYNC 2
`define DINO_V_BACK 33

`define DINO_TICK_CYCLES 2000000

// Object placement
`define DINO_RUNNER_X 100
`define DINO_RUNNER_Y 248
`define DINO_SPRITE_SIZE 32
`define DINO_GROUP_W 64
`define DINO_GROUND_Y 248
`define DINO_PTERO_Y 200
`define DINO_CACTUS_X0 1200
`define DINO_GROUP_X0 1600
`define DINO_LAVA_X0 1800
`define DINO_PTERO_X0 1400
`define DINO_SPEEDUP_PASSES 12

// Score digits and replay banner
`define DINO_SCORE_X 120
`define DINO_SCORE_Y 10
`define DINO_DIGIT_SPACING 16
`define DINO_FONT_SIZE 8
`define DINO_SCORE_DIGITS 5
`define DINO_BANNER_X 560
`define DINO_BANNER_Y 200
`define DINO_BANNER_W 160
`define DINO_BANNER_H 32

`define DINO_RESTART_BIT 4
`define DINO_LFSR_SEED 6'b101011

// Colors as 24-bit RGB
`define DINO_COLOR_SKY 24'h87_CE_EB
`define DINO_COLOR_RUNNER 24'h00_FF_00
`define DINO_COLOR_CACTUS 24'h00_64_00
`define DINO_COLOR_LAVA 24'hFF_8C_00
`define DINO_COLOR_PTERO 24'h80_80_80
`define DINO_COLOR_BLACK 24'h00_00_00

`endif

// File: logic/dino_pkg.sv
/* Runner game shared types */
package dino_pkg;

    // Horizontal position or raster column
    typedef logic [10:0] xcoord_t;

    // Vertical position or raster line
    typedef logic [9:0] ycoord_t;

    // Pixels moved per game tick
    typedef logic [10:0] speed_t;

    typedef logic [3:0] bcd_digit_t;

    typedef logic [7:0] channel_t;

    // Game run state
    typedef enum logic {
        RUNNING,
        OVER
    } run_state_t;

endpackage

// File: logic/raster_timing.sv
/* VGA raster counters */
`timescale 1ns/1ps
`include "dino_consts.svh"

module raster_timing (
    input  logic              clk,
    input  logic              reset,
    output dino_pkg::xcoord_t hcount,
    output dino_pkg::ycoord_t vcount,
    output logic              hsync_n,
    output logic              vsync_n,
    output logic              active
);

    localparam dino_pkg::xcoord_t H_LAST =
        `DINO_H_ACTIVE + `DINO_H_FRONT + `DINO_H_SYNC + `DINO_H_BACK - 1;
    localparam dino_pkg::ycoord_t V_LAST =
        `DINO_V_ACTIVE + `DINO_V_FRONT + `DINO_V_SYNC + `DINO_V_BACK - 1;
    localparam dino_pkg::xcoord_t H_SYNC_START = `DINO_H_ACTIVE + `DINO_H_FRONT;
    localparam dino_pkg::xcoord_t H_SYNC_END = H_SYNC_START + `DINO_H_SYNC;
    localparam dino_pkg::ycoord_t V_SYNC_START = `DINO_V_ACTIVE + `DINO_V_FRONT;
    localparam dino_pkg::ycoord_t V_SYNC_END = V_SYNC_START + `DINO_V_SYNC;

    logic end_of_line;
    logic end_of_field;

    assign end_of_line = (hcount == H_LAST);
    assign end_of_field = (vcount == V_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= end_of_line ? '0 : hcount + 1'b1;
            // Line counter steps once per completed line
            if (end_of_line) begin
                vcount <= end_of_field ? '0 : vcount + 1'b1;
            end
        end
    end

    // Sync pulses are active low
    assign hsync_n = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END));
    assign vsync_n = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END));

    assign active = (hcount < dino_pkg::xcoord_t'(`DINO_H_ACTIVE))
                 && (vcount < dino_pkg::ycoord_t'(`DINO_V_ACTIVE));

endmodule

// File: logic/world_update.sv
/* Hazard motion and game tick */
`timescale 1ns/1ps
`include "dino_consts.svh"

module world_update #(
    parameter int TICK_CYCLES = `DINO_TICK_CYCLES
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              running,
    input  logic              restart,
    output logic              tick,
    output dino_pkg::xcoord_t cactus_x,
    output dino_pkg::xcoord_t group_x,
    output dino_pkg::xcoord_t lava_x,
    output dino_pkg::xcoord_t ptero_x
);

    localparam int DIV_W = $clog2(TICK_CYCLES + 1);

    logic [DIV_W-1:0]  div_cnt;
    logic [5:0]        lfsr;
    logic [3:0]        pass_count;
    dino_pkg::speed_t  speed;
    logic              any_wrap;

    // Leaves the screen at the left edge or moves left by one step
    function automatic dino_pkg::xcoord_t next_x(
        input dino_pkg::xcoord_t x,
        input dino_pkg::speed_t  step,
        input dino_pkg::xcoord_t offset
    );
        dino_pkg::xcoord_t base;
        base = dino_pkg::xcoord_t'(`DINO_H_ACTIVE);
        return (x <= step) ? base + offset : x - step;
    endfunction

    assign any_wrap = (cactus_x <= speed) || (group_x <= speed)
                   || (lava_x <= speed) || (ptero_x <= speed);

    // Tick divider runs only while the game is live
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (!running || restart) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == DIV_W'(TICK_CYCLES - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // LFSR on x^6 + x^5 + 1 survives restart
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `DINO_LFSR_SEED;
        end else if (tick) begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cactus_x   <= dino_pkg::xcoord_t'(`DINO_CACTUS_X0);
            group_x    <= dino_pkg::xcoord_t'(`DINO_GROUP_X0);
            lava_x     <= dino_pkg::xcoord_t'(`DINO_LAVA_X0);
            ptero_x    <= dino_pkg::xcoord_t'(`DINO_PTERO_X0);
            speed      <= dino_pkg::speed_t'(1);
            pass_count <= '0;
        end else if (restart) begin
            cactus_x   <= dino_pkg::xcoord_t'(`DINO_CACTUS_X0);
            group_x    <= dino_pkg::xcoord_t'(`DINO_GROUP_X0);
            lava_x     <= dino_pkg::xcoord_t'(`DINO_LAVA_X0);
            ptero_x    <= dino_pkg::xcoord_t'(`DINO_PTERO_X0);
            speed      <= dino_pkg::speed_t'(1);
            pass_count <= '0;
        end else if (tick) begin
            // Each hazard takes its re-entry offset from its own LFSR slice
            cactus_x <= next_x(cactus_x, speed, dino_pkg::xcoord_t'({lfsr, 3'b000}));
            group_x  <= next_x(group_x, speed, dino_pkg::xcoord_t'({~lfsr, 3'b000}));
            lava_x   <= next_x(lava_x, speed, dino_pkg::xcoord_t'({lfsr[3:0], 5'b00000}));
            ptero_x  <= next_x(ptero_x, speed, dino_pkg::xcoord_t'({lfsr[5:2], 5'b00000}));
            if (pass_count >= 4'(`DINO_SPEEDUP_PASSES)) begin
                speed      <= speed + 1'b1;
                pass_count <= '0;
            end else if (any_wrap) begin
                pass_count <= pass_count + 1'b1;
            end
        end
    end

endmodule

// File: logic/score_counter.sv
/* Decimal score counter */
`timescale 1ns/1ps
`include "dino_consts.svh"

module score_counter (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       tick,
    output dino_pkg::bcd_digit_t [`DINO_SCORE_DIGITS-1:0] score_digits
);

    dino_pkg::bcd_digit_t [`DINO_SCORE_DIGITS-1:0] next_digits;
    logic [`DINO_SCORE_DIGITS:0] carry;

    // Ripple of decimal carries from the least significant digit at index 0
    always_comb begin
        carry[0] = tick;
        for (int i = 0; i < `DINO_SCORE_DIGITS; i++) begin
            if (!carry[i]) begin
                next_digits[i] = score_digits[i];
                carry[i+1]     = 1'b0;
            end else if (score_digits[i] == 4'd9) begin
                next_digits[i] = '0;
                carry[i+1]     = 1'b1;
            end else begin
                next_digits[i] = score_digits[i] + 1'b1;
                carry[i+1]     = 1'b0;
            end
        end
    end

    // 99999 wraps to 00000 through the digit chain
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score_digits <= '0;
        end else if (tick) begin
            score_digits <= next_digits;
        end
    end

endmodule

// File: logic/hazard_monitor.sv
/* Collision check and run state */
`timescale 1ns/1ps
`include "dino_consts.svh"

module hazard_monitor (
    input  logic              clk,
    input  logic              reset,
    input  dino_pkg::xcoord_t cactus_x,
    input  dino_pkg::xcoord_t group_x,
    input  dino_pkg::xcoord_t lava_x,
    input  logic [7:0]        controller_report,
    output logic              running,
    output logic              restart
);

    // Ground row and runner row share the same vertical band
    localparam bit GROUND_ROW =
        (`DINO_GROUND_Y < `DINO_RUNNER_Y + `DINO_SPRITE_SIZE)
        && (`DINO_GROUND_Y + `DINO_SPRITE_SIZE > `DINO_RUNNER_Y);

    dino_pkg::run_state_t state;
    logic                 hit;

    function automatic logic overlaps_runner(input dino_pkg::xcoord_t x, input logic [11:0] w);
        logic [11:0] left;
        logic [11:0] right;
        left  = {1'b0, x};
        right = left + w;
        return GROUND_ROW && (left < 12'(`DINO_RUNNER_X + `DINO_SPRITE_SIZE))
            && (right > 12'(`DINO_RUNNER_X));
    endfunction

    assign hit = overlaps_runner(cactus_x, 12'(`DINO_SPRITE_SIZE))
              || overlaps_runner(group_x, 12'(`DINO_GROUP_W))
              || overlaps_runner(lava_x, 12'(`DINO_SPRITE_SIZE));

    assign running = (state == dino_pkg::RUNNING);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= dino_pkg::RUNNING;
            restart <= 1'b0;
        end else begin
            restart <= 1'b0;
            case (state)
                // Hazards are still at old positions during the restart cycle
                dino_pkg::RUNNING: if (hit && !restart) state <= dino_pkg::OVER;
                dino_pkg::OVER: begin
                    if (controller_report[`DINO_RESTART_BIT]) begin
                        state   <= dino_pkg::RUNNING;
                        restart <= 1'b1;
                    end
                end
                default: state <= dino_pkg::RUNNING;
            endcase
        end
    end

endmodule

// File: logic/pixel_compose.sv
/* Two-stage pixel pipeline */
`timescale 1ns/1ps
`include "dino_consts.svh"

module pixel_compose (
    input  logic                                          clk,
    input  logic                                          reset,
    input  dino_pkg::xcoord_t                             hcount,
    input  dino_pkg::ycoord_t                             vcount,
    input  logic                                          hsync_n,
    input  logic                                          vsync_n,
    input  logic                                          active,
    input  logic                                          running,
    input  dino_pkg::xcoord_t                             cactus_x,
    input  dino_pkg::xcoord_t                             group_x,
    input  dino_pkg::xcoord_t                             lava_x,
    input  dino_pkg::xcoord_t                             ptero_x,
    input  dino_pkg::bcd_digit_t [`DINO_SCORE_DIGITS-1:0] score_digits,
    output dino_pkg::channel_t                            vga_r,
    output dino_pkg::channel_t                            vga_g,
    output dino_pkg::channel_t                            vga_b,
    output logic                                          vga_hs,
    output logic                                          vga_vs,
    output logic                                          vga_blank_n
);

    // Digit glyphs with the top row in the high byte
    localparam logic [63:0] FONT [10] = '{
        64'h3C666E7E76663C00, 64'h1838181818187E00, 64'h3C66061C30667E00,
        64'h3C66061C06663C00, 64'h0C1C2C4C7E0C0C00, 64'h7E607C0606663C00,
        64'h3C66607C66663C00, 64'h7E060C1830303000, 64'h3C66663C66663C00,
        64'h3C66663E06663C00
    };

    logic [11:0]          hx;
    logic [11:0]          vy;
    logic [11:0]          score_off;
    logic [2:0]           digit_idx;
    logic                 in_digit;
    dino_pkg::bcd_digit_t cur_digit;
    logic [2:0]           row_off;

    logic runner_q, cactus_q, group_q, lava_q, ptero_q, banner_q, digit_q;
    logic [7:0] font_row_q;
    logic [2:0] font_col_q;
    logic active_q, hs_q, vs_q, running_q;
    logic [23:0] color;

    function automatic logic in_span(input logic [11:0] pos, input logic [11:0] start,
                                     input logic [11:0] len);
        return (pos >= start) && (pos < start + len);
    endfunction

    assign hx = {1'b0, hcount};
    assign vy = {2'b00, vcount};
    assign score_off = hx - 12'(`DINO_SCORE_X);
    assign digit_idx = score_off[6:4];
    assign row_off = 3'(vcount - dino_pkg::ycoord_t'(`DINO_SCORE_Y));
    // Glyph occupies the first 8 columns of each 16-pixel slot
    assign in_digit = in_span(hx, 12'(`DINO_SCORE_X),
                              12'(`DINO_SCORE_DIGITS * `DINO_DIGIT_SPACING))
                   && !score_off[3]
                   && in_span(vy, 12'(`DINO_SCORE_Y), 12'(`DINO_FONT_SIZE));
    assign cur_digit = in_digit ? score_digits[3'd4 - digit_idx] : '0;

    // Stage 1 rectangle hits and font row
    always_ff @(posedge clk) begin
        runner_q <= in_span(hx, 12'(`DINO_RUNNER_X), 12'(`DINO_SPRITE_SIZE))
                 && in_span(vy, 12'(`DINO_RUNNER_Y), 12'(`DINO_SPRITE_SIZE));
        cactus_q <= in_span(hx, {1'b0, cactus_x}, 12'(`DINO_SPRITE_SIZE))
                 && in_span(vy, 12'(`DINO_GROUND_Y), 12'(`DINO_SPRITE_SIZE));
        group_q <= in_span(hx, {1'b0, group_x}, 12'(`DINO_GROUP_W))
                && in_span(vy, 12'(`DINO_GROUND_Y), 12'(`DINO_SPRITE_SIZE));
        lava_q <= in_span(hx, {1'b0, lava_x}, 12'(`DINO_SPRITE_SIZE))
               && in_span(vy, 12'(`DINO_GROUND_Y), 12'(`DINO_SPRITE_SIZE));
        ptero_q <= in_span(hx, {1'b0, ptero_x}, 12'(`DINO_SPRITE_SIZE))
                && in_span(vy, 12'(`DINO_PTERO_Y), 12'(`DINO_SPRITE_SIZE));
        banner_q <= in_span(hx, 12'(`DINO_BANNER_X), 12'(`DINO_BANNER_W))
                 && in_span(vy, 12'(`DINO_BANNER_Y), 12'(`DINO_BANNER_H));
        digit_q    <= in_digit;
        font_row_q <= FONT[cur_digit][8 * (7 - row_off) +: 8];
        font_col_q <= score_off[2:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q  <= 1'b0;
            hs_q      <= 1'b1;
            vs_q      <= 1'b1;
            running_q <= 1'b1;
        end else begin
            active_q  <= active;
            hs_q      <= hsync_n;
            vs_q      <= vsync_n;
            running_q <= running;
        end
    end

    // Priority rises from sky to score to hazards to runner
    always_comb begin
        color = `DINO_COLOR_SKY;
        if (!active_q) begin
            color = `DINO_COLOR_BLACK;
        end else if (!running_q) begin
            if (banner_q) color = `DINO_COLOR_BLACK;
        end else if (runner_q) begin
            color = `DINO_COLOR_RUNNER;
        end else if (cactus_q || group_q) begin
            color = `DINO_COLOR_CACTUS;
        end else if (lava_q) begin
            color = `DINO_COLOR_LAVA;
        end else if (ptero_q) begin
            color = `DINO_COLOR_PTERO;
        end else if (digit_q && font_row_q[~font_col_q]) begin
            color = `DINO_COLOR_BLACK;
        end
    end

    // Stage 2 color with aligned sync and blank
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= `DINO_COLOR_BLACK;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            {vga_r, vga_g, vga_b} <= color;
            vga_hs      <= hs_q;
            vga_vs      <= vs_q;
            vga_blank_n <= active_q;
        end
    end

endmodule

// File: logic/dino_top.sv
/* Runner game top level */
`timescale 1ns/1ps
`include "dino_consts.svh"

module dino_top #(
    parameter int TICK_CYCLES = `DINO_TICK_CYCLES
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [7:0]                                    controller_report,
    output dino_pkg::channel_t                            vga_r,
    output dino_pkg::channel_t                            vga_g,
    output dino_pkg::channel_t                            vga_b,
    output logic                                          vga_hs,
    output logic                                          vga_vs,
    output logic                                          vga_blank_n,
    output logic                                          vga_clk,
    output logic                                          game_over,
    output dino_pkg::bcd_digit_t [`DINO_SCORE_DIGITS-1:0] score_digits
);

    dino_pkg::xcoord_t hcount;
    dino_pkg::ycoord_t vcount;
    logic              hsync_n;
    logic              vsync_n;
    logic              active;
    logic              tick;
    logic              running;
    logic              restart;
    dino_pkg::xcoord_t cactus_x;
    dino_pkg::xcoord_t group_x;
    dino_pkg::xcoord_t lava_x;
    dino_pkg::xcoord_t ptero_x;

    assign vga_clk = hcount[0];
    assign game_over = !running;

    raster_timing u_raster (
        .clk, .reset, .hcount, .vcount, .hsync_n, .vsync_n, .active
    );

    world_update #(.TICK_CYCLES(TICK_CYCLES)) u_world (
        .clk, .reset, .running, .restart, .tick,
        .cactus_x, .group_x, .lava_x, .ptero_x
    );

    score_counter u_score (.clk, .reset, .tick, .score_digits);

    hazard_monitor u_monitor (
        .clk, .reset, .cactus_x, .group_x, .lava_x,
        .controller_report, .running, .restart
    );

    pixel_compose u_pixels (
        .clk, .reset, .hcount, .vcount, .hsync_n, .vsync_n, .active, .running,
        .cactus_x, .group_x, .lava_x, .ptero_x, .score_digits,
        .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vga_blank_n
    );

endmodule

// File: dv/dino_tb.sv
/* Runner game testbench */
`timescale 1ns/1ps
`include "dino_consts.svh"

module dino_tb;

    localparam int H_TOTAL = `DINO_H_ACTIVE + `DINO_H_FRONT + `DINO_H_SYNC + `DINO_H_BACK;
    localparam int V_TOTAL = `DINO_V_ACTIVE + `DINO_V_FRONT + `DINO_V_SYNC + `DINO_V_BACK;
    localparam int TICK = 16;
    // Cactus steps one pixel per tick until it reaches the runner's right edge
    localparam int TICKS_TO_HIT = `DINO_CACTUS_X0 - (`DINO_RUNNER_X + `DINO_SPRITE_SIZE - 1);
    localparam int LIMIT = 4 * H_TOTAL * V_TOTAL;

    logic       clk;
    logic       reset;
    logic [7:0] controller_report;
    dino_pkg::channel_t vga_r, vga_g, vga_b;
    logic vga_hs, vga_vs, vga_blank_n, vga_clk, game_over;
    dino_pkg::bcd_digit_t [`DINO_SCORE_DIGITS-1:0] score_digits;
    logic [23:0] pixel;

    int    errors [5];
    int    checks [5];
    string test_names [5] = '{"raster timing", "score", "collision", "restart", "pixels"};
    int    line, col, frame;
    int    hs_period, hs_low, vs_low, blank_high;
    int    tick_gap, ticks_since_start, cur_score, prev_score;
    int    runner_seen, over_seen, banner_seen;
    int    cycle_count, restart_delay, total;
    logic  hs_prev, vs_prev, blank_prev, prev_bit4, gap_valid;
    logic [3:0] go_hist, go_now;
    integer seed;

    assign pixel = {vga_r, vga_g, vga_b};

    dino_top #(.TICK_CYCLES(TICK)) uut (
        .clk, .reset, .controller_report, .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs,
        .vga_blank_n, .vga_clk, .game_over, .score_digits
    );

    task automatic report_mismatch(input int test, input string name,
                                   input longint expected, input longint actual);
        errors[test]++;
        $display("mismatch at time %0t: %s expected 0x%0h got 0x%0h",
                 $time, name, expected, actual);
    endtask

    task automatic report_failure(input int test, input string msg);
        errors[test]++;
        $display("error at time %0t: %s", $time, msg);
    endtask

    task automatic check_value(input int test, input string name,
                               input longint expected, input longint actual);
        checks[test]++;
        assert (actual == expected) else report_mismatch(test, name, expected, actual);
    endtask

    task automatic finish_test(input int idx);
        $display("%s: %0d checks, %0d errors", test_names[idx], checks[idx], errors[idx]);
    endtask

    // Integer value of the digits with the most significant at the top index
    function automatic int score_value(input dino_pkg::bcd_digit_t [`DINO_SCORE_DIGITS-1:0] d);
        int v;
        v = 0;
        for (int k = `DINO_SCORE_DIGITS - 1; k >= 0; k--) begin
            v = v * 10 + int'(d[k]);
        end
        return v;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            line = -1;
            col = 0;
            frame = 0;
            hs_period = -1;
            hs_low = 0;
            vs_low = 0;
            blank_high = 0;
            hs_prev = 1'b1;
            vs_prev = 1'b1;
            blank_prev = 1'b0;
            prev_score = 0;
            tick_gap = 0;
            gap_valid = 1'b0;
            ticks_since_start = 0;
            go_hist = '0;
            prev_bit4 = 1'b0;
        end else begin
            cur_score = score_value(score_digits);
            go_now = {go_hist[2:0], game_over};
            if (hs_period >= 0) hs_period++;
            if (!vga_hs && hs_prev) begin
                if (hs_period >= 0) check_value(0, "vga_hs period", H_TOTAL, hs_period);
                hs_period = 0;
                hs_low = 0;
            end
            if (!vga_hs) hs_low++;
            if (vga_hs && !hs_prev) check_value(0, "vga_hs low width", `DINO_H_SYNC, hs_low);
            if (!vga_vs && vs_prev) begin
                check_value(0, "active lines per frame", `DINO_V_ACTIVE, line + 1);
                vs_low = 0;
                frame++;
                line = -1;
            end
            if (!vga_vs) vs_low++;
            if (vga_vs && !vs_prev) begin
                check_value(0, "vga_vs low width", `DINO_V_SYNC * H_TOTAL, vs_low);
            end
            if (vga_blank_n && !blank_prev) begin
                blank_high = 0;
                col = 0;
                line++;
            end else begin
                col++;
            end
            if (vga_blank_n) blank_high++;
            if (!vga_blank_n && blank_prev) begin
                check_value(0, "vga_blank_n high width", `DINO_H_ACTIVE, blank_high);
            end
            // vga_clk follows column parity since blank rises at hcount 2
            if (vga_blank_n) check_value(0, "vga_clk", col % 2, vga_clk);

            if (cur_score != prev_score) begin
                if (game_over) begin
                    report_mismatch(2, "score_digits while over", prev_score, cur_score);
                end else begin
                    for (int k = 0; k < `DINO_SCORE_DIGITS; k++) begin
                        assert (score_digits[k] <= 4'd9)
                            else report_mismatch(1, "score digit", 9, score_digits[k]);
                    end
                    check_value(1, "score_digits", (prev_score + 1) % 100000, cur_score);
                    if (gap_valid) check_value(1, "score step interval", TICK, tick_gap);
                    gap_valid = 1'b1;
                    tick_gap = 0;
                    ticks_since_start++;
                end
            end
            tick_gap++;
            if (game_over) gap_valid = 1'b0;

            if (game_over && !go_hist[0]) begin
                check_value(2, "ticks before collision", TICKS_TO_HIT, ticks_since_start);
            end
            if (!game_over && go_hist[0]) begin
                check_value(3, "controller_report[4] before restart", 1, prev_bit4);
                ticks_since_start = 0;
            end

            if (line == 100 && col == 0) check_value(4, "sky pixel", `DINO_COLOR_SKY, pixel);
            if (line == `DINO_RUNNER_Y && col == `DINO_RUNNER_X && go_now == 4'b0000) begin
                check_value(4, "runner pixel", `DINO_COLOR_RUNNER, pixel);
                runner_seen++;
            end
            if (line == `DINO_RUNNER_Y && col == `DINO_RUNNER_X && &go_now) begin
                check_value(4, "runner column while over", `DINO_COLOR_SKY, pixel);
                over_seen++;
            end
            if (line == `DINO_BANNER_Y + 10 && col >= `DINO_BANNER_X
                    && col < `DINO_BANNER_X + `DINO_BANNER_W && &go_now) begin
                check_value(4, "banner pixel", `DINO_COLOR_BLACK, pixel);
                banner_seen++;
            end

            hs_prev = vga_hs;
            vs_prev = vga_vs;
            blank_prev = vga_blank_n;
            prev_score = cur_score;
            prev_bit4 = controller_report[`DINO_RESTART_BIT];
            go_hist = go_now;
        end
    end

    // Watchdog sized to four full frames
    initial begin
        cycle_count = 0;
        while (cycle_count < LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("error at time %0t: run did not complete within %0d cycles", $time, LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        seed = 32'h9340_665b;
        reset = 1'b1;
        controller_report = 8'h00;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_value(1, "game_over after reset", 0, game_over);
        check_value(1, "score_digits after reset", 0, score_value(score_digits));
        @(posedge game_over);
        @(negedge clk);
        finish_test(2);
        // Restart late in the frame so the next run crosses the runner line
        wait (line == 238);
        restart_delay = ($random(seed) & 32'h0FFF) + 1;
        repeat (restart_delay) @(posedge clk);
        #10;
        controller_report[`DINO_RESTART_BIT] = 1'b1;
        @(posedge clk);
        #10;
        controller_report[`DINO_RESTART_BIT] = 1'b0;
        @(posedge game_over);
        @(negedge clk);
        finish_test(3);
        wait (frame == 1 && line == `DINO_RUNNER_Y + 1);
        if (runner_seen == 0) report_failure(4, "runner pixel never sampled while running");
        if (over_seen == 0) report_failure(4, "runner column never sampled while over");
        if (banner_seen == 0) report_failure(4, "banner never sampled while over");
        finish_test(0);
        finish_test(1);
        finish_test(4);
        total = 0;
        for (int k = 0; k < 5; k++) begin
            if (checks[k] == 0) report_failure(k, {test_names[k], " made no checks"});
            total += errors[k];
        end
        $display("5 tests run, %0d errors in total", total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+logic
logic/dino_pkg.sv
logic/raster_timing.sv
logic/world_update.sv
logic/score_counter.sv
logic/hazard_monitor.sv
logic/pixel_compose.sv
logic/dino_top.sv
dv/dino_tb.sv

// File: Bender.yml
package:
  name: dino_runner

sources:
  - include_dirs:
      - logic
    files:
      - logic/dino_pkg.sv
      - logic/raster_timing.sv
      - logic/world_update.sv
      - logic/score_counter.sv
      - logic/hazard_monitor.sv
      - logic/pixel_compose.sv
      - logic/dino_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/dino_tb.sv
